// File: core.f
hw/common.sv
hw/pipes.sv
hw/fetch.sv
hw/decode.sv
hw/hazard.sv
hw/execute.sv
hw/mem_wb.sv
hw/core.sv
verif/core_assertions.sv
verif/core_tb.sv

// File: run.sh
#!/bin/sh
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module core_tb -Mdir obj_dir -f core.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vcore_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "NO ERRORS"; then
    exit 0
fi
exit 1

// File: verif/core_tb.sv
`timescale 1ns/1ps

module core_tb
    import common::*;
    import pipes::*;
();

    localparam int ROWS      = 7;
    localparam int DIRECTED  = 4;
    localparam int MAX_LEN   = 16;
    localparam int LOAD_SPAN = 32;
    localparam int QUIET     = 6;

    logic    clk;
    logic    arst_n;
    u1       run;
    u1       load_en;
    u5       load_addr;
    word_t   load_instr;
    commit_t commit;

    word_t   prog     [ROWS][MAX_LEN];
    commit_t expected [ROWS][MAX_LEN];
    int      prog_len [ROWS];
    int      exp_len  [ROWS];
    word_t   model    [32];
    int      row;
    int      limit;
    int      cycles = 0;

    core i_dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .run        (run),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_instr (load_instr),
        .commit     (commit)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        assert (cycles < limit) else begin
            $display("timeout after %0d cycles, the core stopped committing", cycles);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("ERRORS FOUND");
        $fatal(1, "stopped at the first error");
    endtask

    // small assembler
    function automatic word_t rtype(funct_t fn, creg_addr_t rd, creg_addr_t rs, creg_addr_t rt);
        return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t itype(opcode_t op, creg_addr_t rt, creg_addr_t rs,
                                    logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t jtype(logic [25:0] target);
        return {OP_J, target};
    endfunction

    function automatic void asm(word_t w);
        prog[row][prog_len[row]] = w;
        prog_len[row]++;
    endfunction

    function automatic void want_reg(creg_addr_t d, word_t v);
        expected[row][exp_len[row]] = '{valid: 1'b1, is_store: 1'b0, dst: d, addr: '0, data: v};
        exp_len[row]++;
    endfunction

    function automatic void want_store(word_t a, word_t v);
        expected[row][exp_len[row]] = '{valid: 1'b1, is_store: 1'b1, dst: '0, addr: a, data: v};
        exp_len[row]++;
    endfunction

    task automatic build_directed();
        // ALU chain through every forwarding path
        row = 0;
        asm(itype(OP_ADDIU, 5'd1, 5'd0, 16'd5));
        want_reg(5'd1, 32'd5);
        asm(itype(OP_ADDIU, 5'd2, 5'd1, 16'd3));
        want_reg(5'd2, 32'd8);
        asm(rtype(FN_ADDU, 5'd3, 5'd1, 5'd2));
        want_reg(5'd3, 32'd13);
        asm(rtype(FN_SUBU, 5'd4, 5'd3, 5'd1));
        want_reg(5'd4, 32'd8);
        asm(rtype(FN_OR, 5'd5, 5'd4, 5'd3));
        want_reg(5'd5, 32'd13);
        asm(rtype(FN_AND, 5'd6, 5'd5, 5'd2));
        want_reg(5'd6, 32'd8);
        asm(rtype(FN_SLT, 5'd7, 5'd2, 5'd5));
        want_reg(5'd7, 32'd1);
        asm(itype(OP_LUI, 5'd8, 5'd0, 16'h1234));
        want_reg(5'd8, 32'h1234_0000);
        asm(itype(OP_ORI, 5'd8, 5'd8, 16'habcd));
        want_reg(5'd8, 32'h1234_abcd);
        asm(itype(OP_LUI, 5'd9, 5'd0, 16'h8000));
        want_reg(5'd9, 32'h8000_0000);
        asm(rtype(FN_SLT, 5'd10, 5'd9, 5'd1));
        want_reg(5'd10, 32'd1);
        asm(itype(OP_ADDIU, 5'd11, 5'd0, 16'hffff));
        want_reg(5'd11, 32'hffff_ffff);
        asm(rtype(FN_SUBU, 5'd12, 5'd1, 5'd2));
        want_reg(5'd12, 32'hffff_fffd);
        // store, load back, load-use stalls incl. a branch
        row = 1;
        asm(itype(OP_ADDIU, 5'd1, 5'd0, 16'h0040));
        want_reg(5'd1, 32'h0000_0040);
        asm(itype(OP_LUI, 5'd2, 5'd0, 16'hdead));
        want_reg(5'd2, 32'hdead_0000);
        asm(itype(OP_ORI, 5'd2, 5'd2, 16'hbeef));
        want_reg(5'd2, 32'hdead_beef);
        asm(itype(OP_SW, 5'd2, 5'd1, 16'd4));
        want_store(32'h0000_0044, 32'hdead_beef);
        asm(itype(OP_LW, 5'd3, 5'd1, 16'd4));
        want_reg(5'd3, 32'hdead_beef);
        asm(rtype(FN_ADDU, 5'd4, 5'd3, 5'd1));
        want_reg(5'd4, 32'hdead_bf2f);
        asm(itype(OP_SW, 5'd4, 5'd1, 16'd0));
        want_store(32'h0000_0040, 32'hdead_bf2f);
        asm(itype(OP_LW, 5'd5, 5'd1, 16'd0));
        want_reg(5'd5, 32'hdead_bf2f);
        asm(itype(OP_BEQ, 5'd4, 5'd5, 16'd1));
        asm(itype(OP_ADDIU, 5'd6, 5'd0, 16'd1));
        asm(itype(OP_ADDIU, 5'd7, 5'd5, 16'd1));
        want_reg(5'd7, 32'hdead_bf30);
        // taken and not-taken beq, j
        row = 2;
        asm(itype(OP_ADDIU, 5'd1, 5'd0, 16'd7));
        want_reg(5'd1, 32'd7);
        asm(itype(OP_ADDIU, 5'd2, 5'd0, 16'd7));
        want_reg(5'd2, 32'd7);
        asm(itype(OP_BEQ, 5'd2, 5'd1, 16'd1));
        asm(itype(OP_ADDIU, 5'd3, 5'd0, 16'h0011));
        asm(itype(OP_BEQ, 5'd0, 5'd1, 16'd1));
        asm(itype(OP_ADDIU, 5'd4, 5'd0, 16'h0022));
        want_reg(5'd4, 32'h0000_0022);
        asm(jtype(26'd8));
        asm(itype(OP_ADDIU, 5'd5, 5'd0, 16'h0033));
        asm(itype(OP_ADDIU, 5'd6, 5'd4, 16'd1));
        want_reg(5'd6, 32'h0000_0023);
        asm(itype(OP_BEQ, 5'd6, 5'd6, 16'd1));
        asm(itype(OP_ADDIU, 5'd7, 5'd0, 16'h0044));
        asm(itype(OP_ADDIU, 5'd8, 5'd6, 16'd2));
        want_reg(5'd8, 32'h0000_0025);
        // r0 stays zero and never commits
        row = 3;
        asm(itype(OP_ADDIU, 5'd0, 5'd0, 16'h0055));
        asm(rtype(FN_ADDU, 5'd1, 5'd0, 5'd0));
        want_reg(5'd1, 32'd0);
        asm(itype(OP_ADDIU, 5'd0, 5'd0, 16'd9));
        asm(itype(OP_LUI, 5'd0, 5'd0, 16'd1));
        asm(itype(OP_ORI, 5'd2, 5'd0, 16'd7));
        want_reg(5'd2, 32'd7);
        asm(rtype(FN_ADDU, 5'd3, 5'd0, 5'd2));
        want_reg(5'd3, 32'd7);
        asm(itype(OP_SW, 5'd0, 5'd0, 16'd8));
        want_store(32'd8, 32'd0);
        asm(itype(OP_LW, 5'd4, 5'd0, 16'd8));
        want_reg(5'd4, 32'd0);
        asm(rtype(FN_ADDU, 5'd0, 5'd4, 5'd4));
        asm(itype(OP_ADDIU, 5'd5, 5'd0, 16'd3));
        want_reg(5'd5, 32'd3);
    endtask

    // addiu/addu chain on r1..r4, reference values from a plain register model
    task automatic build_random(int r);
        creg_addr_t  d;
        creg_addr_t  s;
        creg_addr_t  t;
        logic [15:0] imm;
        row = r;
        for (int k = 1; k <= 4; k++) begin
            imm = 16'($urandom);
            d = creg_addr_t'(k);
            model[d] = {{16{imm[15]}}, imm};
            asm(itype(OP_ADDIU, d, 5'd0, imm));
            want_reg(d, model[d]);
        end
        for (int k = 4; k < MAX_LEN; k++) begin
            d = creg_addr_t'(1 + $urandom_range(3));
            s = creg_addr_t'(1 + $urandom_range(3));
            t = creg_addr_t'(1 + $urandom_range(3));
            imm = 16'($urandom);
            if ($urandom_range(1) == 0) begin
                model[d] = model[s] + {{16{imm[15]}}, imm};
                asm(itype(OP_ADDIU, d, s, imm));
            end else begin
                model[d] = model[s] + model[t];
                asm(rtype(FN_ADDU, d, s, t));
            end
            want_reg(d, model[d]);
        end
    endtask

    task automatic check_commit(int r, int n);
        commit_t e;
        e = expected[r][n];
        assert (commit.is_store == e.is_store) else begin
            $display("MISMATCH commit.is_store row %0d event %0d: got %h expected %h",
                     r, n, commit.is_store, e.is_store);
            abort_run();
        end
        assert (commit.dst == e.dst) else begin
            $display("MISMATCH commit.dst row %0d event %0d: got %h expected %h",
                     r, n, commit.dst, e.dst);
            abort_run();
        end
        assert (commit.addr == e.addr) else begin
            $display("MISMATCH commit.addr row %0d event %0d: got %h expected %h",
                     r, n, commit.addr, e.addr);
            abort_run();
        end
        assert (commit.data == e.data) else begin
            $display("MISMATCH commit.data row %0d event %0d: got %h expected %h",
                     r, n, commit.data, e.data);
            abort_run();
        end
    endtask

    task automatic run_row(int r);
        int got;
        int waited;
        int budget;
        got     = 0;
        waited  = 0;
        budget  = prog_len[r] * 3 + 20;
        arst_n  = 1'b0;
        run     = 1'b0;
        load_en = 1'b0;
        repeat (8) @(negedge clk);
        arst_n = 1'b1;
        // unused words load as zero, which decodes as a nop
        for (int a = 0; a < LOAD_SPAN; a++) begin
            load_en    = 1'b1;
            load_addr  = u5'(a);
            load_instr = (a < prog_len[r]) ? prog[r][a] : '0;
            @(negedge clk);
            assert (!commit.valid) else begin
                $display("row %0d: commit seen while the core is not running", r);
                abort_run();
            end
        end
        load_en = 1'b0;
        run     = 1'b1;
        while (got < exp_len[r] && waited < budget) begin
            @(negedge clk);
            waited++;
            if (commit.valid) begin
                check_commit(r, got);
                got++;
            end
        end
        assert (got == exp_len[r]) else begin
            $display("row %0d: only %0d of %0d expected commits arrived", r, got, exp_len[r]);
            abort_run();
        end
        repeat (QUIET) begin
            @(negedge clk);
            assert (!commit.valid) else begin
                $display("row %0d: unexpected extra commit after the program ended", r);
                abort_run();
            end
        end
        run = 1'b0;
    endtask

    initial begin
        arst_n     = 1'b0;
        run        = 1'b0;
        load_en    = 1'b0;
        load_addr  = '0;
        load_instr = '0;
        void'($urandom(32'h3aab_639b));
        build_directed();
        for (int r = DIRECTED; r < ROWS; r++) begin
            build_random(r);
        end
        // per row budget plus reset, load and quiet window
        limit = 0;
        for (int r = 0; r < ROWS; r++) begin
            limit += prog_len[r] * 3 + 40 + 8 + LOAD_SPAN + QUIET;
        end
        for (int r = 0; r < ROWS; r++) begin
            run_row(r);
        end
        if (i_dut.i_core_assertions.fail_count == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("ERRORS FOUND");
            $fatal(1, "bound assertions reported failures");
        end
    end

endmodule

// File: verif/core_assertions.sv
`timescale 1ns/1ps

module core_assertions
    import pipes::*;
(
    input logic           clk,
    input logic           arst_n,
    input logic           jump,
    input hazard_data_out hz,
    input fetch_data_out  fetch_q,
    input decode_data_out decode_q
);

    int unsigned fail_count = 0;

    // load-use stall holds fetch/decode and bubbles decode/execute
    assert property (@(posedge clk) disable iff (!arst_n)
                     hz.stall |=> ($stable(fetch_q) && decode_q == '0))
        else begin
            $error("stall did not hold fetch/decode or bubble decode/execute");
            fail_count++;
        end

    // a resolved redirect leaves a bubble in fetch/decode
    assert property (@(posedge clk) disable iff (!arst_n)
                     (jump && !hz.stall) |=> !fetch_q.valid)
        else begin
            $error("taken jump or branch did not bubble fetch/decode");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!arst_n)
                     $rose(arst_n) |-> !(hz.stall || hz.clear1 || hz.clear2))
        else begin
            $error("pipeline control set right after reset");
            fail_count++;
        end

endmodule

bind core core_assertions i_core_assertions (
    .clk      (clk),
    .arst_n   (arst_n),
    .jump     (jump),
    .hz       (hazard_q),
    .fetch_q  (fetch_q),
    .decode_q (decode_q)
);

// File: hw/core.sv
`timescale 1ns/1ps

module core
    import common::*;
    import pipes::*;
(
    input  logic    clk,
    input  logic    arst_n,
    input  u1       run,
    input  u1       load_en,
    input  u5       load_addr,
    input  word_t   load_instr,
    output commit_t commit
);

    fetch_data_out   fetch_q;
    decode_data_out  decode_q;
    execute_data_out execute_q;
    hazard_data_out  hazard_q;
    forward_data_out fwd_execute;
    forward_data_out fwd_memory;
    forward_data_out fwd_writeback;
    creg_addr_t      rs;
    creg_addr_t      rt;
    creg_addr_t      ex_dst;
    creg_addr_t      wb_dst;
    u1               jump;
    u1               ex_regwrite;
    u1               ex_memread;
    u1               wb_en;
    word_t           jump_target;
    word_t           wb_data;

    fetch i_fetch (
        .clk         (clk),
        .arst_n      (arst_n),
        .run         (run),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_instr  (load_instr),
        .stall       (hazard_q.stall),
        .clear2      (hazard_q.clear2),
        .jump        (jump),
        .jump_target (jump_target),
        .fetch_out   (fetch_q)
    );

    decode i_decode (
        .clk         (clk),
        .arst_n      (arst_n),
        .fetch_in    (fetch_q),
        .hazard_in   (hazard_q),
        .wb_en       (wb_en),
        .wb_dst      (wb_dst),
        .wb_data     (wb_data),
        .rs          (rs),
        .rt          (rt),
        .jump        (jump),
        .jump_target (jump_target),
        .decode_out  (decode_q)
    );

    hazard i_hazard (
        .jump              (jump),
        .regwrite          (ex_regwrite),
        .memread           (ex_memread),
        .rs                (rs),
        .rt                (rt),
        .dst               (ex_dst),
        .forward_execute   (fwd_execute),
        .forward_memory    (fwd_memory),
        .forward_writeback (fwd_writeback),
        .hazardOut         (hazard_q)
    );

    execute i_execute (
        .clk             (clk),
        .arst_n          (arst_n),
        .decode_in       (decode_q),
        .execute_out     (execute_q),
        .forward_execute (fwd_execute),
        .regwrite        (ex_regwrite),
        .memread         (ex_memread),
        .dst             (ex_dst)
    );

    mem_wb i_mem_wb (
        .clk               (clk),
        .arst_n            (arst_n),
        .execute_in        (execute_q),
        .forward_memory    (fwd_memory),
        .forward_writeback (fwd_writeback),
        .wb_en             (wb_en),
        .wb_dst            (wb_dst),
        .wb_data           (wb_data),
        .commit            (commit)
    );

endmodule

// File: hw/mem_wb.sv
`timescale 1ns/1ps

module mem_wb
    import common::*;
    import pipes::*;
(
    input  logic            clk,
    input  logic            arst_n,
    input  execute_data_out execute_in,
    output forward_data_out forward_memory,
    output forward_data_out forward_writeback,
    output u1               wb_en,
    output creg_addr_t      wb_dst,
    output word_t           wb_data,
    output commit_t         commit
);

    word_t   dmem [DMEM_WORDS];
    word_t   load_data;
    word_t   mem_value;
    u1       reg_write;
    commit_t wb_next;
    commit_t wb_q;

    assign load_data = dmem[execute_in.result[DMEM_AW+1:2]];

    always_ff @(posedge clk) begin
        if (execute_in.memwrite) begin
            dmem[execute_in.result[DMEM_AW+1:2]] <= execute_in.store_data;
        end
    end

    assign mem_value = execute_in.memread ? load_data : execute_in.result;
    assign reg_write = execute_in.regwrite && execute_in.dst != '0;

    assign forward_memory = '{valid: reg_write, dst: execute_in.dst, data: mem_value};

    always_comb begin
        wb_next.valid    = reg_write || execute_in.memwrite;
        wb_next.is_store = execute_in.memwrite;
        wb_next.dst      = execute_in.memwrite ? '0 : execute_in.dst;
        wb_next.addr     = execute_in.memwrite ? execute_in.result : '0;
        wb_next.data     = execute_in.memwrite ? execute_in.store_data : mem_value;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_q <= '0;
        end else begin
            wb_q <= wb_next;
        end
    end

    assign wb_en             = wb_q.valid && !wb_q.is_store;
    assign wb_dst            = wb_q.dst;
    assign wb_data           = wb_q.data;
    assign forward_writeback = '{valid: wb_en, dst: wb_q.dst, data: wb_q.data};
    assign commit            = wb_q;

endmodule

// File: hw/execute.sv
`timescale 1ns/1ps

module execute
    import common::*;
    import pipes::*;
(
    input  logic            clk,
    input  logic            arst_n,
    input  decode_data_out  decode_in,
    output execute_data_out execute_out,
    output forward_data_out forward_execute,
    output u1               regwrite,
    output u1               memread,
    output creg_addr_t      dst
);

    word_t alu_y;

    always_comb begin
        case (decode_in.alu_op)
            ALU_ADD: alu_y = decode_in.srca + decode_in.srcb;
            ALU_SUB: alu_y = decode_in.srca - decode_in.srcb;
            ALU_AND: alu_y = decode_in.srca & decode_in.srcb;
            ALU_OR:  alu_y = decode_in.srca | decode_in.srcb;
            ALU_SLT: alu_y = {31'd0, $signed(decode_in.srca) < $signed(decode_in.srcb)};
            ALU_LUI: alu_y = {decode_in.srcb[15:0], 16'h0000};
            default: alu_y = '0;
        endcase
    end

    // load data not ready yet, hazard stalls instead
    assign forward_execute = '{
        valid: decode_in.regwrite && !decode_in.memread && decode_in.dst != '0,
        dst:   decode_in.dst,
        data:  alu_y
    };

    assign regwrite = decode_in.regwrite;
    assign memread  = decode_in.memread;
    assign dst      = decode_in.dst;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            execute_out <= '0;
        end else begin
            execute_out <= '{result: alu_y, store_data: decode_in.store_data, dst: decode_in.dst,
                             regwrite: decode_in.regwrite, memread: decode_in.memread,
                             memwrite: decode_in.memwrite};
        end
    end

endmodule

// File: hw/hazard.sv
`timescale 1ns/1ps

module hazard
    import common::*;
    import pipes::*;
(
    input  u1               jump,
    input  u1               regwrite,
    input  u1               memread,
    input  creg_addr_t      rs,
    input  creg_addr_t      rt,
    input  creg_addr_t      dst,
    input  forward_data_out forward_execute,
    input  forward_data_out forward_memory,
    input  forward_data_out forward_writeback,
    output hazard_data_out  hazardOut
);

    forward_data_out fwd_a;
    forward_data_out fwd_b;
    u1               load_use;

    // youngest matching source wins
    function automatic forward_data_out pick(
        input creg_addr_t      r,
        input forward_data_out e,
        input forward_data_out m,
        input forward_data_out w
    );
        forward_data_out p;
        p = '0;
        if (r != '0) begin
            if (e.valid && e.dst == r) begin
                p = e;
            end else if (m.valid && m.dst == r) begin
                p = m;
            end else if (w.valid && w.dst == r) begin
                p = w;
            end
        end
        return p;
    endfunction

    // load in execute feeding the instruction in decode
    assign load_use = regwrite && memread && dst != '0 && (dst == rs || dst == rt);

    assign fwd_a = pick(rs, forward_execute, forward_memory, forward_writeback);
    assign fwd_b = pick(rt, forward_execute, forward_memory, forward_writeback);

    always_comb begin
        hazardOut.stall        = load_use;
        hazardOut.clear1       = load_use;
        // a stalled branch redirects one cycle later
        hazardOut.clear2       = jump && !load_use;
        hazardOut.srca_mux     = fwd_a.valid;
        hazardOut.srca_forward = fwd_a.data;
        hazardOut.srcb_mux     = fwd_b.valid;
        hazardOut.srcb_forward = fwd_b.data;
    end

endmodule

// File: hw/decode.sv
`timescale 1ns/1ps

module decode
    import common::*;
    import pipes::*;
(
    input  logic           clk,
    input  logic           arst_n,
    input  fetch_data_out  fetch_in,
    input  hazard_data_out hazard_in,
    input  u1              wb_en,
    input  creg_addr_t     wb_dst,
    input  word_t          wb_data,
    output creg_addr_t     rs,
    output creg_addr_t     rt,
    output u1              jump,
    output word_t          jump_target,
    output decode_data_out decode_out
);

    instr_u         ins;
    word_t          regs [32];
    word_t          pc_plus4;
    word_t          imm;
    word_t          imm_sext;
    word_t          rs_val;
    word_t          rt_val;
    word_t          opa;
    word_t          opb;
    decode_data_out ctl;
    decode_data_out dec_next;
    u1              use_imm;
    u1              zext;
    u1              rs_used;
    u1              rt_used;
    u1              is_beq;
    u1              is_j;

    assign ins = fetch_in.instr;

    always_comb begin
        ctl     = '0;
        use_imm = 1'b0;
        zext    = 1'b0;
        rs_used = 1'b0;
        rt_used = 1'b0;
        is_beq  = 1'b0;
        is_j    = 1'b0;
        if (fetch_in.valid) begin
            case (ins.r.opcode)
                OP_RTYPE: begin
                    rs_used      = 1'b1;
                    rt_used      = 1'b1;
                    ctl.dst      = ins.r.rd;
                    ctl.regwrite = 1'b1;
                    case (ins.r.funct)
                        FN_ADDU: ctl.alu_op = ALU_ADD;
                        FN_SUBU: ctl.alu_op = ALU_SUB;
                        FN_AND:  ctl.alu_op = ALU_AND;
                        FN_OR:   ctl.alu_op = ALU_OR;
                        FN_SLT:  ctl.alu_op = ALU_SLT;
                        default: ctl.regwrite = 1'b0;
                    endcase
                end
                OP_ADDIU, OP_LW: begin
                    rs_used      = 1'b1;
                    use_imm      = 1'b1;
                    ctl.dst      = ins.i.rt;
                    ctl.regwrite = 1'b1;
                    ctl.memread  = (ins.i.opcode == OP_LW);
                end
                OP_ORI, OP_LUI: begin
                    rs_used      = (ins.i.opcode == OP_ORI);
                    use_imm      = 1'b1;
                    zext         = 1'b1;
                    ctl.dst      = ins.i.rt;
                    ctl.regwrite = 1'b1;
                    ctl.alu_op   = (ins.i.opcode == OP_ORI) ? ALU_OR : ALU_LUI;
                end
                OP_SW: begin
                    rs_used      = 1'b1;
                    rt_used      = 1'b1;
                    use_imm      = 1'b1;
                    ctl.memwrite = 1'b1;
                end
                OP_BEQ: begin
                    rs_used = 1'b1;
                    rt_used = 1'b1;
                    is_beq  = 1'b1;
                end
                OP_J:    is_j = 1'b1;
                default: ;
            endcase
        end
    end

    // unused source fields read as r0 so they never match a hazard
    assign rs = rs_used ? ins.r.rs : '0;
    assign rt = rt_used ? ins.r.rt : '0;

    assign rs_val = (rs == '0) ? '0 : regs[rs];
    assign rt_val = (rt == '0) ? '0 : regs[rt];
    assign opa    = hazard_in.srca_mux ? hazard_in.srca_forward : rs_val;
    assign opb    = hazard_in.srcb_mux ? hazard_in.srcb_forward : rt_val;

    assign imm_sext = {{16{ins.i.imm16[15]}}, ins.i.imm16};
    assign imm      = zext ? {16'h0000, ins.i.imm16} : imm_sext;
    assign pc_plus4 = fetch_in.pc + 32'd4;

    // branches resolve here, no delay slot
    assign jump        = is_j || (is_beq && opa == opb);
    assign jump_target = is_j ? {pc_plus4[31:28], ins.i.rs, ins.i.rt, ins.i.imm16, 2'b00}
                              : pc_plus4 + {imm_sext[29:0], 2'b00};

    always_comb begin
        dec_next            = ctl;
        dec_next.srca       = opa;
        dec_next.srcb       = use_imm ? imm : opb;
        dec_next.store_data = opb;
    end

    always_ff @(posedge clk) begin
        if (wb_en && wb_dst != '0) begin
            regs[wb_dst] <= wb_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            decode_out <= '0;
        end else if (hazard_in.clear1) begin
            decode_out <= '0;
        end else begin
            decode_out <= dec_next;
        end
    end

endmodule

// File: hw/fetch.sv
`timescale 1ns/1ps

module fetch
    import common::*;
    import pipes::*;
(
    input  logic          clk,
    input  logic          arst_n,
    input  u1             run,
    input  u1             load_en,
    input  u5             load_addr,
    input  word_t         load_instr,
    input  u1             stall,
    input  u1             clear2,
    input  u1             jump,
    input  word_t         jump_target,
    output fetch_data_out fetch_out
);

    word_t imem [IMEM_WORDS];
    word_t pc;
    word_t fetched;

    // program load port
    always_ff @(posedge clk) begin
        if (load_en) begin
            imem[IMEM_AW'(load_addr)] <= load_instr;
        end
    end

    assign fetched = imem[pc[IMEM_AW+1:2]];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= PC_RESET;
        end else if (!stall) begin
            if (jump) begin
                pc <= jump_target;
            end else if (run) begin
                pc <= pc + 32'd4;
            end
        end
    end

    // redirect or idle core gives a bubble
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fetch_out <= '0;
        end else if (!stall) begin
            if (clear2 || !run) begin
                fetch_out <= '0;
            end else begin
                fetch_out <= '{pc: pc, instr: fetched, valid: 1'b1};
            end
        end
    end

endmodule

// File: hw/pipes.sv
package pipes;

    import common::*;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI
    } alu_op_t;

    // fetch/decode register
    typedef struct packed {
        word_t pc;
        word_t instr;
        u1     valid;
    } fetch_data_out;

    // decode/execute register
    typedef struct packed {
        alu_op_t    alu_op;
        word_t      srca;
        word_t      srcb;
        word_t      store_data;
        creg_addr_t dst;
        u1          regwrite;
        u1          memread;
        u1          memwrite;
    } decode_data_out;

    // execute/memory register
    typedef struct packed {
        word_t      result;
        word_t      store_data;
        creg_addr_t dst;
        u1          regwrite;
        u1          memread;
        u1          memwrite;
    } execute_data_out;

    typedef struct packed {
        u1          valid;
        creg_addr_t dst;
        word_t      data;
    } forward_data_out;

    typedef struct packed {
        u1     stall;
        u1     clear1;
        u1     clear2;
        u1     srca_mux;
        word_t srca_forward;
        u1     srcb_mux;
        word_t srcb_forward;
    } hazard_data_out;

    // one architectural write, register or store
    typedef struct packed {
        u1          valid;
        u1          is_store;
        creg_addr_t dst;
        word_t      addr;
        word_t      data;
    } commit_t;

endpackage

// File: hw/common.sv
package common;

    typedef logic        u1;
    typedef logic [4:0]  u5;
    typedef logic [31:0] u32;

    typedef u5  creg_addr_t;
    typedef u32 word_t;

    // supported primary opcodes
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_ADDIU = 6'h09,
        OP_ORI   = 6'h0d,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_t;

    // function field of r-type
    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } funct_t;

    typedef struct packed {
        opcode_t    opcode;
        creg_addr_t rs;
        creg_addr_t rt;
        creg_addr_t rd;
        u5          shamt;
        funct_t     funct;
    } r_fields;

    typedef struct packed {
        opcode_t     opcode;
        creg_addr_t  rs;
        creg_addr_t  rt;
        logic [15:0] imm16;
    } i_fields;

    // same word, two views
    typedef union packed {
        r_fields r;
        i_fields i;
    } instr_u;

    localparam int    IMEM_WORDS = 64;
    localparam int    DMEM_WORDS = 64;
    localparam int    IMEM_AW    = $clog2(IMEM_WORDS);
    localparam int    DMEM_AW    = $clog2(DMEM_WORDS);
    localparam word_t PC_RESET   = 32'h0000_0000;

endpackage
